/* logic/hart_pkg.sv */
`default_nettype none
// ==============================
// Hart shared types
// Opcodes, ALU codes, stage records
// ==============================

package hart_pkg;

    localparam int XLEN   = 32;     // Data and address width
    localparam int REG_AW = 5;      // Register index width

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP     = 7'b0110011,    // Register ALU
        OPC_OP_IMM = 7'b0010011,    // Immediate ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,          // Signed compare
        ALU_PASS_B = 3'd6           // LUI result
    } alu_op_e;

    // ==============================
    // Instruction formats
    // ==============================
    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_11_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_4_0;
        opcode_e           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic              imm_12;
        logic [5:0]        imm_10_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm_4_1;
        logic              imm_11;
        opcode_e           opcode;
    } b_fmt_t;

    // One word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } inst_u;

    // ==============================
    // Pipeline records
    // ==============================
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;       // Operand B from immediate
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    branch_ne;     // BNE, else BEQ
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        ctrl_t             ctrl;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   alu_result;  // Also the data address
        logic [XLEN-1:0]   store_data;
        ctrl_t             ctrl;
    } ex_mem_t;

    // Write-back record, also the retire view
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
        logic              reg_write;
    } wb_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Fetch stage
// PC sequencing and IF/ID register
// ==============================

module fetch_stage import hart_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,        // Load-use hold
    input  logic            i_redirect,     // Taken branch in EX
    input  logic [XLEN-1:0] i_redirect_pc,
    input  logic [XLEN-1:0] i_imem_rdata,   // Same-cycle answer
    output logic [XLEN-1:0] o_imem_addr,
    output if_id_t          o_if_id
);

    logic [XLEN-1:0] pc;

    // Redirect wins over stall
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= RESET_ADDR;
        end else if (i_redirect) begin
            pc <= i_redirect_pc;
        end else if (!i_stall) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign o_imem_addr = pc;

    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_if_id.pc   <= pc;
            o_if_id.inst <= i_imem_rdata;   // Word viewed through the union downstream
        end
        if (i_rst || i_redirect) begin
            o_if_id.valid <= 1'b0;          // Younger word dropped on a taken branch
        end else if (!i_stall) begin
            o_if_id.valid <= 1'b1;
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_imem_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Decode stage
// Control, immediates, register file, load-use
// ==============================

module decode_stage import hart_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  if_id_t i_if_id,
    input  logic   i_redirect,  // Flush the word in ID
    input  wb_t    i_wb,        // Register write port
    output logic   o_stall,
    output id_ex_t o_id_ex
);

    inst_u             inst;
    ctrl_t             ctrl;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   regs [2**REG_AW];

    assign inst = i_if_id.inst;
    assign rs1  = inst.r.rs1;   // Same bit slots in every format
    assign rs2  = inst.r.rs2;

    // ==============================
    // Control decode
    // ==============================
    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        case (inst.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.use_imm   = (inst.r.opcode == OPC_OP_IMM);
                ctrl.reg_write = 1'b1;
                case (inst.r.funct3)
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    // funct7 is immediate bits for ADDI
                    default: ctrl.alu_op = (inst.r.opcode == OPC_OP && inst.r.funct7[5])
                                           ? ALU_SUB : ALU_ADD;
                endcase
            end
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.use_imm   = 1'b1;      // Base plus offset
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_STORE: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = inst.b.funct3[0];  // 001 is BNE
            end
            default: ;                              // Unknown word does nothing
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (inst.r.opcode)
            OPC_OP_IMM, OPC_LOAD:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            OPC_STORE:
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            OPC_BRANCH:
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            // Upper immediate covers the R fields above rd
            OPC_LUI:
                imm = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
            default:
                imm = '0;
        endcase
    end

    // ==============================
    // Register file
    // ==============================
    always_ff @(posedge i_clk) begin
        if (i_wb.valid && i_wb.reg_write && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.wdata;
        end
    end

    // x0 reads zero, same-cycle write bypassed
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
        if (addr == '0) return '0;
        if (i_wb.valid && i_wb.reg_write && i_wb.rd == addr) return i_wb.wdata;
        return regs[addr];
    endfunction

    // Load in EX feeding this word
    assign o_stall = i_if_id.valid && o_id_ex.valid && o_id_ex.ctrl.mem_read
                     && o_id_ex.rd != '0 && (o_id_ex.rd == rs1 || o_id_ex.rd == rs2);

    // ID/EX register
    always_ff @(posedge i_clk) begin
        o_id_ex.pc       <= i_if_id.pc;
        o_id_ex.rs1      <= rs1;
        o_id_ex.rs2      <= rs2;
        o_id_ex.rd       <= inst.r.rd;
        o_id_ex.rs1_data <= rf_read(rs1);
        o_id_ex.rs2_data <= rf_read(rs2);
        o_id_ex.imm      <= imm;
        o_id_ex.ctrl     <= ctrl;
        if (i_rst) begin
            o_id_ex.valid <= 1'b0;
        end else begin
            o_id_ex.valid <= i_if_id.valid && !o_stall && !i_redirect;  // Bubble
        end
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Execute stage
// Forwarding, ALU, branch resolve
// ==============================

module execute_stage import hart_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  id_ex_t          i_id_ex,
    input  wb_t             i_wb,           // Oldest forward source
    output logic            o_redirect,
    output logic [XLEN-1:0] o_redirect_pc,
    output ex_mem_t         o_ex_mem
);

    logic            mem_fwd_ok;
    logic            wb_fwd_ok;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    // Load data is not ready in MEM, that case is stalled in ID
    assign mem_fwd_ok = o_ex_mem.valid && o_ex_mem.ctrl.reg_write && !o_ex_mem.ctrl.mem_read;
    assign wb_fwd_ok  = i_wb.valid && i_wb.reg_write;

    // Youngest producer first
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] src,
                                            input logic [XLEN-1:0]   rf_val);
        if (src == '0) return rf_val;
        if (mem_fwd_ok && o_ex_mem.rd == src) return o_ex_mem.alu_result;
        if (wb_fwd_ok && i_wb.rd == src) return i_wb.wdata;
        return rf_val;
    endfunction

    assign op_a    = fwd(i_id_ex.rs1, i_id_ex.rs1_data);
    assign rs2_val = fwd(i_id_ex.rs2, i_id_ex.rs2_data);    // Also store data
    assign op_b    = i_id_ex.ctrl.use_imm ? i_id_ex.imm : rs2_val;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // BEQ/BNE, equality flipped for NE
    assign o_redirect    = i_id_ex.valid && i_id_ex.ctrl.is_branch
                           && ((op_a == rs2_val) != i_id_ex.ctrl.branch_ne);
    assign o_redirect_pc = i_id_ex.pc + i_id_ex.imm;

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        o_ex_mem.pc         <= i_id_ex.pc;
        o_ex_mem.rd         <= i_id_ex.rd;
        o_ex_mem.alu_result <= alu_result;
        o_ex_mem.store_data <= rs2_val;
        o_ex_mem.ctrl       <= i_id_ex.ctrl;
        if (i_rst) begin
            o_ex_mem.valid <= 1'b0;
        end else begin
            o_ex_mem.valid <= i_id_ex.valid;    // Flushed entries arrive invalid
        end
    end

    // Taken branch is real and the two words behind it never execute
    a_redirect_flush: assert property (@(posedge i_clk) disable iff (i_rst)
        o_redirect |-> (i_id_ex.valid && i_id_ex.ctrl.is_branch)
                       ##1 !i_id_ex.valid ##1 !i_id_ex.valid);

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Memory stage
// Data memory access, MEM/WB register
// ==============================

module memory_stage import hart_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  ex_mem_t         i_ex_mem,
    input  logic [XLEN-1:0] i_dmem_rdata,   // Same-cycle answer
    output logic [XLEN-1:0] o_dmem_addr,
    output logic            o_dmem_ren,
    output logic            o_dmem_wen,
    output logic [XLEN-1:0] o_dmem_wdata,
    output wb_t             o_wb
);

    logic [XLEN-1:0] wdata;

    // Word access only
    assign o_dmem_addr  = i_ex_mem.alu_result;
    assign o_dmem_ren   = i_ex_mem.valid && i_ex_mem.ctrl.mem_read;
    assign o_dmem_wen   = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;
    assign o_dmem_wdata = i_ex_mem.store_data;

    assign wdata = i_ex_mem.ctrl.mem_read ? i_dmem_rdata : i_ex_mem.alu_result;

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        o_wb.pc        <= i_ex_mem.pc;
        o_wb.rd        <= i_ex_mem.rd;
        o_wb.wdata     <= wdata;
        o_wb.reg_write <= i_ex_mem.ctrl.reg_write;
        if (i_rst) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_ex_mem.valid;
        end
    end

    // A read is exclusive and always retires a register write
    a_ren_wen: assert property (@(posedge i_clk) disable iff (i_rst)
        o_dmem_ren |-> !o_dmem_wen ##1 (o_wb.valid && o_wb.reg_write));

endmodule

`default_nettype wire

/* logic/hart.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Hart top level
// Five-stage RV32I subset pipeline
// ==============================

module hart import hart_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic              i_clk,
    input  logic              i_rst,
    // Instruction memory
    output logic [XLEN-1:0]   o_imem_addr,
    input  logic [XLEN-1:0]   i_imem_rdata,
    // Data memory
    output logic [XLEN-1:0]   o_dmem_addr,
    output logic              o_dmem_ren,
    output logic              o_dmem_wen,
    output logic [XLEN-1:0]   o_dmem_wdata,
    input  logic [XLEN-1:0]   i_dmem_rdata,
    // Retire port
    output logic              o_retire_valid,
    output logic [XLEN-1:0]   o_retire_pc,
    output logic [REG_AW-1:0] o_retire_rd,
    output logic [XLEN-1:0]   o_retire_wdata,
    output logic              o_retire_reg_write
);

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;            // Regfile write, forward source, retire
    logic            stall;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    fetch_stage #(
        .RESET_ADDR(RESET_ADDR)
    ) u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_imem_rdata  (i_imem_rdata),
        .o_imem_addr   (o_imem_addr),
        .o_if_id       (if_id)
    );

    decode_stage u_decode (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_if_id    (if_id),
        .i_redirect (redirect),
        .i_wb       (wb),
        .o_stall    (stall),
        .o_id_ex    (id_ex)
    );

    execute_stage u_execute (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_id_ex       (id_ex),
        .i_wb          (wb),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_ex_mem      (ex_mem)
    );

    memory_stage u_memory (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ex_mem     (ex_mem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata),
        .o_wb         (wb)
    );

    // Retire view of the write-back record
    assign o_retire_valid     = wb.valid;
    assign o_retire_pc        = wb.pc;
    assign o_retire_rd        = wb.rd;
    assign o_retire_wdata     = wb.wdata;
    assign o_retire_reg_write = wb.reg_write;

endmodule

`default_nettype wire

/* bench/clock_reset.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Bench clock and reset
// ==============================

module clock_reset (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;     // 100 ns period
    end

    // Held for four rising edges, dropped just after the last
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/hart_tb.sv */
`timescale 1ns/1ns
`default_nettype none
// ==============================
// Hart testbench
// Random program against an in-order model
// ==============================

module hart_tb;

    localparam logic [31:0] RESET_ADDR = 32'h0000_1000;
    localparam int          PROG_LEN   = 200;               // End loop included
    localparam int          END_IDX    = PROG_LEN - 1;
    localparam int          DMEM_WORDS = 64;
    localparam logic [31:0] NOP        = 32'h0000_0013;     // ADDI x0,x0,0

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI,
        K_LW, K_SW, K_BEQ, K_BNE
    } kind_e;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        retire_reg_write;

    // Program fields
    kind_e       kind      [PROG_LEN];
    logic [4:0]  rd_f      [PROG_LEN];
    logic [4:0]  rs1_f     [PROG_LEN];
    logic [4:0]  rs2_f     [PROG_LEN];
    logic [31:0] imm_f     [PROG_LEN];
    logic [31:0] imem      [PROG_LEN];
    logic [31:0] dmem      [DMEM_WORDS];    // Bench data memory
    logic [31:0] model_mem [DMEM_WORDS];    // Model's data memory
    // Expected retire, load and store streams
    logic [31:0] exp_pc    [PROG_LEN];
    logic [4:0]  exp_rd    [PROG_LEN];
    logic [31:0] exp_wdata [PROG_LEN];
    logic        exp_we    [PROG_LEN];
    logic [31:0] ld_addr   [PROG_LEN];
    logic [31:0] st_addr   [PROG_LEN];
    logic [31:0] st_data   [PROG_LEN];
    int          n_ret;
    int          n_ld;
    int          n_st;
    int          ret_idx;
    int          ld_idx;
    int          st_idx;
    int          err_retire;
    int          err_load;
    int          err_store;
    int          err_other;
    logic        in_reset;

    clock_reset u_clk_rst (
        .o_clk (clk),
        .o_rst (rst)
    );

    hart #(
        .RESET_ADDR(RESET_ADDR)
    ) DUT (
        .i_clk              (clk),
        .i_rst              (rst),
        .o_imem_addr        (imem_addr),
        .i_imem_rdata       (imem_rdata),
        .o_dmem_addr        (dmem_addr),
        .o_dmem_ren         (dmem_ren),
        .o_dmem_wen         (dmem_wen),
        .o_dmem_wdata       (dmem_wdata),
        .i_dmem_rdata       (dmem_rdata),
        .o_retire_valid     (retire_valid),
        .o_retire_pc        (retire_pc),
        .o_retire_rd        (retire_rd),
        .o_retire_wdata     (retire_wdata),
        .o_retire_reg_write (retire_reg_write)
    );

    // ==============================
    // Program and reference model
    // ==============================
    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        case (k)
            K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            K_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            K_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_LUI:  return {imm[31:12], rd, 7'b0110111};
            K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            default: return NOP;
        endcase
    endfunction

    task automatic build_program();
        int sel;
        for (int i = 0; i < END_IDX; i++) begin
            sel = $urandom % 15;
            if (sel >= int'(K_BEQ) && i > END_IDX - 6) sel = int'(K_ADDI);  // No jump past the end
            kind[i]  = kind_e'(sel);
            rd_f[i]  = 5'(1 + $urandom % 7);        // Writers never target x0
            rs1_f[i] = 5'($urandom % 8);            // Few registers, many hazards
            rs2_f[i] = 5'($urandom % 8);
            imm_f[i] = ($urandom % 32) - 32'd16;    // Small signed immediate
            case (kind[i])
                K_LUI: imm_f[i] = {20'($urandom), 12'h000};
                K_LW, K_SW: begin
                    rs1_f[i] = 5'd0;                // x0 base, aligned offset
                    imm_f[i] = ($urandom % DMEM_WORDS) * 4;
                end
                K_BEQ, K_BNE: begin
                    imm_f[i] = (2 + $urandom % 5) * 4;  // 2 to 6 words forward
                    if ($urandom % 4 == 0) rs2_f[i] = rs1_f[i];
                end
                default: ;
            endcase
        end
        kind[END_IDX]  = K_BEQ;                     // Self-loop BEQ x0,x0,0
        rd_f[END_IDX]  = 5'd0;
        rs1_f[END_IDX] = 5'd0;
        rs2_f[END_IDX] = 5'd0;
        imm_f[END_IDX] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = encode(kind[i], rd_f[i], rs1_f[i], rs2_f[i], imm_f[i]);
        end
    endtask

    // In-order execution up to the first pass through the end loop
    task automatic run_model();
        logic [31:0] x [8];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic        we;
        int          idx;
        int          next;
        for (int r = 0; r < 8; r++) x[r] = '0;
        idx   = 0;
        n_ret = 0;
        n_ld  = 0;
        n_st  = 0;
        while (n_ret < PROG_LEN) begin
            a    = x[rs1_f[idx]];
            b    = x[rs2_f[idx]];
            addr = a + imm_f[idx];
            res  = '0;
            we   = 1'b1;
            next = idx + 1;
            case (kind[idx])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = a + imm_f[idx];
                K_ANDI: res = a & imm_f[idx];
                K_ORI:  res = a | imm_f[idx];
                K_XORI: res = a ^ imm_f[idx];
                K_LUI:  res = imm_f[idx];
                K_LW: begin
                    res           = model_mem[addr[7:2]];
                    ld_addr[n_ld] = addr;
                    n_ld++;
                end
                K_SW: begin
                    we                   = 1'b0;
                    st_addr[n_st]        = addr;
                    st_data[n_st]        = b;
                    model_mem[addr[7:2]] = b;
                    n_st++;
                end
                default: begin                      // BEQ or BNE
                    we = 1'b0;
                    if (kind[idx] == K_BEQ ? a == b : a != b) begin
                        next = idx + int'(imm_f[idx] >> 2);
                    end
                end
            endcase
            exp_pc[n_ret]    = RESET_ADDR + 32'(idx * 4);
            exp_rd[n_ret]    = rd_f[idx];
            exp_wdata[n_ret] = res;
            exp_we[n_ret]    = we;
            n_ret++;
            if (we) x[rd_f[idx]] = res;
            if (idx == END_IDX) break;
            idx = next;
        end
    endtask

    // ==============================
    // Memory models and checks
    // ==============================
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] word_idx;
        word_idx = (addr - RESET_ADDR) >> 2;
        if (word_idx < 32'(PROG_LEN)) return imem[word_idx];
        return NOP;                                 // Beyond the program
    endfunction

    task automatic check_load();
        assert (ld_idx < n_ld && dmem_addr == ld_addr[ld_idx])
        else begin
            err_load++;
            $display("[ERROR] %0t load %0d: addr %h, expected addr %h",
                     $time, ld_idx, dmem_addr, ld_addr[ld_idx]);
        end
        ld_idx++;
    endtask

    task automatic check_store();
        assert (st_idx < n_st && dmem_addr == st_addr[st_idx] && dmem_wdata == st_data[st_idx])
        else begin
            err_store++;
            $display("[ERROR] %0t store %0d: addr %h data %h, expected addr %h data %h",
                     $time, st_idx, dmem_addr, dmem_wdata, st_addr[st_idx], st_data[st_idx]);
        end
        dmem[dmem_addr[7:2]] = dmem_wdata;
        st_idx++;
    endtask

    task automatic check_retire();
        if (ret_idx < n_ret) begin
            assert (retire_pc == exp_pc[ret_idx] && retire_reg_write == exp_we[ret_idx]
                    && (!exp_we[ret_idx] || (retire_rd == exp_rd[ret_idx]
                                             && retire_wdata == exp_wdata[ret_idx])))
            else begin
                err_retire++;
                $display("[ERROR] %0t retire %0d: pc %h we %b rd %0d wdata %h", $time,
                         ret_idx, retire_pc, retire_reg_write, retire_rd, retire_wdata);
                $display("[ERROR] %0t   expected pc %h we %b rd %0d wdata %h", $time,
                         exp_pc[ret_idx], exp_we[ret_idx], exp_rd[ret_idx], exp_wdata[ret_idx]);
            end
            ret_idx++;
        end else begin
            // Only the end loop may keep retiring
            assert (retire_pc == exp_pc[n_ret-1]) else begin
                err_retire++;
                $display("[ERROR] %0t retire past end loop at pc %h", $time, retire_pc);
            end
        end
    endtask

    always @(posedge clk) begin
        if (in_reset) begin
            assert (!retire_valid && !dmem_ren && !dmem_wen) else begin
                err_other++;
                $display("[ERROR] %0t retire or memory strobe high in reset", $time);
            end
        end
        in_reset = rst;
        if (dmem_ren) check_load();
        if (dmem_wen) check_store();
        if (retire_valid) check_retire();
        #1;                                         // Memories answer just after the edge
        imem_rdata = fetch_word(imem_addr);
        dmem_rdata = dmem[dmem_addr[7:2]];
    end

    // ==============================
    // Run control
    // ==============================
    initial begin
        int cycles;
        void'($urandom(70));
        imem_rdata = NOP;
        dmem_rdata = '0;
        in_reset   = 1'b0;
        ret_idx    = 0;
        ld_idx     = 0;
        st_idx     = 0;
        err_retire = 0;
        err_load   = 0;
        err_store  = 0;
        err_other  = 0;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            dmem[w]      = 32'h5A00_0000 ^ (32'(w * 4) * 32'h0001_0003);   // Full address mixed in
            model_mem[w] = dmem[w];
        end
        build_program();
        run_model();

        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            err_other++;
            $display("Reset was never released");
        end

        cycles = 0;
        while (ret_idx < n_ret && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (ret_idx < n_ret) begin
            err_other++;
            $display("Timeout: hart retired only %0d of %0d instructions in 5000 cycles",
                     ret_idx, n_ret);
        end

        assert (ld_idx == n_ld) else begin
            err_load++;
            $display("[ERROR] %0t %0d loads seen, expected %0d", $time, ld_idx, n_ld);
        end
        assert (st_idx == n_st) else begin
            err_store++;
            $display("[ERROR] %0t %0d stores seen, expected %0d", $time, st_idx, n_st);
        end
        for (int w = 0; w < DMEM_WORDS; w++) begin
            assert (dmem[w] == model_mem[w]) else begin
                err_store++;
                $display("[ERROR] %0t data word %0d is %h, expected %h",
                         $time, w, dmem[w], model_mem[w]);
            end
        end

        $display("Summary: %0d retired, %0d loads, %0d stores, errors retire %0d load %0d store %0d other %0d",
                 ret_idx, ld_idx, st_idx, err_retire, err_load, err_store, err_other);
        if (err_retire + err_load + err_store + err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/hart_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hart.sv
bench/clock_reset.sv
bench/hart_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the hart regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module hart_tb -o hart_sim -f all.f
./obj_dir/hart_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
exit 1
